//--- src/align_macros.svh
`ifndef ALIGN_MACROS_SVH
`define ALIGN_MACROS_SVH

// Word width of the fetch bus, also used for addresses
`define ALIGN_XLEN 32

// Response buffer entries
// Three words cover a straddling instruction plus two in flight
`define ALIGN_DEPTH 3

// Buffer pointer width
`define ALIGN_PTR_W 2

// Outstanding fetch requests allowed at once
`define ALIGN_CREDITS 2

// Width of the credit and flush counters
`define ALIGN_CNT_W 2

`endif

//--- src/fetch_bus_pkg.sv
`default_nettype none

`include "align_macros.svh"

package fetch_bus_pkg;

  // One word returned by the prefetcher
  typedef struct packed {
    logic [`ALIGN_XLEN-1:0] rdata;
    logic                   err;
  } fetch_resp_t;

  // Redirect info sent along with a fetch request
  // Branch address is always word aligned
  typedef struct packed {
    logic                   branch;
    logic [`ALIGN_XLEN-1:0] branch_addr;
  } fetch_req_t;

  // Outstanding request and flush counter
  typedef logic [`ALIGN_CNT_W-1:0] credit_cnt_t;

endpackage

`default_nettype wire

//--- src/fetch_ctrl_pkg.sv
`default_nettype none

`include "align_macros.svh"

package fetch_ctrl_pkg;

  // Commands from the controller FSM
  typedef struct packed {
    logic instr_req;
    logic pc_set;
    logic kill;
  } fetch_cmd_t;

  // Instruction handed to decode
  // Compressed instructions sit in the low 16 bits
  typedef struct packed {
    logic [`ALIGN_XLEN-1:0] instr;
    logic                   err;
    logic [`ALIGN_XLEN-1:0] addr;
  } instr_out_t;

  // Complete instructions held in the buffer, one bit of headroom
  typedef logic [`ALIGN_CNT_W:0] instr_cnt_t;

endpackage

`default_nettype wire

//--- src/fetch_req_ctrl.sv
`default_nettype none

`include "align_macros.svh"

module fetch_req_ctrl
  import fetch_bus_pkg::*;
  import fetch_ctrl_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire fetch_cmd_t cmd_i,
  input  wire logic       fetch_ready_i,
  input  wire logic       resp_valid_i,
  input  wire logic [1:0] n_incoming_i,
  input  wire logic       emit_i,
  output logic            fetch_valid_o,
  output logic            resp_push_o,
  output logic            busy_o
);

  credit_cnt_t credit_cnt_q, credit_cnt_n;
  credit_cnt_t flush_cnt_q, flush_cnt_n;
  credit_cnt_t flush_on_branch;
  instr_cnt_t  instr_cnt_q, instr_cnt_n;
  instr_cnt_t  instr_cnt_adj;
  logic        pop_q;
  logic        grant;

  ////////////////////
  // Request decision
  ////////////////////

  // Emitted instruction is subtracted one cycle late
  assign instr_cnt_adj = instr_cnt_q - instr_cnt_t'(pop_q);

  // Fetch when nearly empty, or always on a redirect, never without a free credit
  assign fetch_valid_o = cmd_i.instr_req &&
                         (credit_cnt_q < credit_cnt_t'(`ALIGN_CREDITS)) &&
                         ((instr_cnt_adj == '0) ||
                          ((instr_cnt_adj == instr_cnt_t'(1)) && (credit_cnt_q == '0)) ||
                          cmd_i.pc_set);

  assign grant  = fetch_valid_o && fetch_ready_i;
  assign busy_o = (credit_cnt_q != '0) || fetch_valid_o;

  // Stale words from before a branch never reach the buffer
  assign resp_push_o = resp_valid_i && (flush_cnt_q == '0);

  ////////////////////
  // Counters
  ////////////////////

  always_comb begin
    credit_cnt_n = credit_cnt_q;
    if (grant && !resp_valid_i) begin
      credit_cnt_n = credit_cnt_q + credit_cnt_t'(1);
    end else if (!grant && resp_valid_i) begin
      credit_cnt_n = credit_cnt_q - credit_cnt_t'(1);
    end
  end

  // A response in the kill cycle is already gone, so it needs no flush
  assign flush_on_branch = credit_cnt_q - credit_cnt_t'(cmd_i.kill && resp_valid_i);

  always_comb begin
    flush_cnt_n = flush_cnt_q;
    if (cmd_i.pc_set) begin
      flush_cnt_n = flush_on_branch;
    end else if (resp_valid_i && (flush_cnt_q != '0)) begin
      flush_cnt_n = flush_cnt_q - credit_cnt_t'(1);
    end
  end

  always_comb begin
    if (cmd_i.kill) begin
      // Buffer content is dropped on a kill
      instr_cnt_n = '0;
    end else begin
      instr_cnt_n = instr_cnt_q + instr_cnt_t'(n_incoming_i) - instr_cnt_t'(pop_q);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_cnt_q <= '0;
      flush_cnt_q  <= '0;
      instr_cnt_q  <= '0;
      pop_q        <= 1'b0;
    end else begin
      credit_cnt_q <= credit_cnt_n;
      flush_cnt_q  <= flush_cnt_n;
      instr_cnt_q  <= instr_cnt_n;
      pop_q        <= emit_i;
    end
  end

  // Throttle keeps the prefetcher within its credits
  credit_bound_a: assert property (@(posedge clk) disable iff (!rst_n)
    credit_cnt_q <= credit_cnt_t'(`ALIGN_CREDITS));

endmodule

`default_nettype wire

//--- src/resp_predecode.sv
`default_nettype none

`include "align_macros.svh"

module resp_predecode
  import fetch_bus_pkg::*;
  import fetch_ctrl_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire fetch_cmd_t             cmd_i,
  input  wire logic [`ALIGN_XLEN-1:0] branch_addr_i,
  input  wire logic                   resp_push_i,
  input  wire fetch_resp_t            resp_i,
  output logic [1:0]                  n_incoming_o
);

  // Write side alignment state
  // Unaligned and complete only right after an unaligned branch
  logic aligned_q, aligned_n;
  logic complete_q, complete_n;
  logic lo_full;
  logic hi_full;

  // Low bits 11 start a 32-bit instruction
  assign lo_full = resp_i.rdata[1:0] == 2'b11;
  assign hi_full = resp_i.rdata[17:16] == 2'b11;

  always_comb begin
    aligned_n    = aligned_q;
    complete_n   = complete_q;
    n_incoming_o = 2'd0;
    if (cmd_i.pc_set) begin
      aligned_n  = !branch_addr_i[1];
      complete_n = branch_addr_i[1];
    end else if (resp_push_i) begin
      if (aligned_q && lo_full) begin
        // Whole word is one instruction, state unchanged
        n_incoming_o = 2'd1;
      end else if (aligned_q || !complete_q) begin
        // Lower half ends an instruction, either compressed or straddling
        if (hi_full) begin
          n_incoming_o = 2'd1;
          aligned_n    = 1'b0;
          complete_n   = 1'b0;
        end else begin
          n_incoming_o = 2'd2;
          aligned_n    = 1'b1;
          complete_n   = 1'b1;
        end
      end else begin
        // Unaligned branch target, lower half is skipped
        if (hi_full) begin
          n_incoming_o = 2'd0;
          aligned_n    = 1'b0;
          complete_n   = 1'b0;
        end else begin
          n_incoming_o = 2'd1;
          aligned_n    = 1'b1;
          complete_n   = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      aligned_q  <= 1'b1;
      complete_q <= 1'b1;
    end else begin
      aligned_q  <= aligned_n;
      complete_q <= complete_n;
    end
  end

endmodule

`default_nettype wire

//--- src/resp_fifo.sv
`default_nettype none

`include "align_macros.svh"

module resp_fifo
  import fetch_bus_pkg::*;
  import fetch_ctrl_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire fetch_cmd_t  cmd_i,
  input  wire logic        resp_push_i,
  input  wire fetch_resp_t resp_i,
  input  wire logic        pop_i,
  output fetch_resp_t      head_o,
  output fetch_resp_t      next_o,
  output logic             head_valid_o,
  output logic             next_valid_o
);

  typedef logic [`ALIGN_PTR_W-1:0] ptr_t;

  fetch_resp_t             mem_q [`ALIGN_DEPTH];
  logic [`ALIGN_DEPTH-1:0] valid_q, valid_n;
  ptr_t                    wptr_q;
  ptr_t                    rptr_q;
  ptr_t                    rptr_next;
  logic                    push_en;

  // Ring increment, wraps after the last entry
  function automatic ptr_t ptr_inc(input ptr_t ptr);
    ptr_inc = (ptr == ptr_t'(`ALIGN_DEPTH - 1)) ? '0 : ptr + ptr_t'(1);
  endfunction

  // Nothing is written while the fetch stage is killed
  assign push_en   = resp_push_i && !cmd_i.kill;
  assign rptr_next = ptr_inc(rptr_q);

  ////////////////////
  // Read side
  ////////////////////

  assign head_o       = mem_q[rptr_q];
  assign next_o       = mem_q[rptr_next];
  assign head_valid_o = valid_q[rptr_q];
  assign next_valid_o = valid_q[rptr_next];

  ////////////////////
  // Valid bits
  ////////////////////

  // Set before clear, so a word pushed and used up at once leaves no entry
  always_comb begin
    valid_n = valid_q;
    if (push_en) begin
      valid_n[wptr_q] = 1'b1;
    end
    if (pop_i) begin
      valid_n[rptr_q] = 1'b0;
    end
    if (cmd_i.kill) begin
      valid_n = '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      wptr_q  <= '0;
      rptr_q  <= '0;
    end else begin
      valid_q <= valid_n;
      if (cmd_i.pc_set) begin
        // Branch target lands in entry zero
        wptr_q <= '0;
        rptr_q <= '0;
      end else begin
        if (push_en) begin
          wptr_q <= ptr_inc(wptr_q);
        end
        if (pop_i) begin
          rptr_q <= rptr_next;
        end
      end
    end
  end

  // Payload storage
  always_ff @(posedge clk) begin
    if (push_en) begin
      mem_q[wptr_q] <= resp_i;
    end
  end

  // Request throttling upstream must keep a free slot for every response
  no_overwrite_a: assert property (@(posedge clk) disable iff (!rst_n)
    push_en |-> !valid_q[wptr_q]);

endmodule

`default_nettype wire

//--- src/instr_realigner.sv
`default_nettype none

`include "align_macros.svh"

module instr_realigner
  import fetch_bus_pkg::*;
  import fetch_ctrl_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire fetch_cmd_t             cmd_i,
  input  wire logic [`ALIGN_XLEN-1:0] branch_addr_i,
  input  wire logic                   resp_push_i,
  input  wire fetch_resp_t            resp_i,
  input  wire fetch_resp_t            head_i,
  input  wire fetch_resp_t            next_i,
  input  wire logic                   head_valid_i,
  input  wire logic                   next_valid_i,
  input  wire logic                   instr_ready_i,
  output logic                        instr_valid_o,
  output instr_out_t                  instr_o,
  output logic                        pop_o,
  output logic                        emit_o
);

  logic [`ALIGN_XLEN-1:0] addr_q, addr_n;
  logic [`ALIGN_XLEN-1:0] addr_incr;
  fetch_resp_t            cur_word;
  fetch_resp_t            second_word;
  logic                   valid_any;
  logic                   valid_straddle;
  logic                   aligned_is_c;
  logic                   unaligned_is_c;
  logic                   err_unaligned;

  ////////////////////
  // Word selection
  ////////////////////

  // Current word is the head, or the incoming response when the buffer is empty
  assign cur_word    = head_valid_i ? head_i : resp_i;
  // Second half of a straddling instruction, from the next slot or the response
  assign second_word = next_valid_i ? next_i : resp_i;

  assign valid_any      = head_valid_i || resp_push_i;
  // Straddle needs the head plus either the next slot or a fresh word
  assign valid_straddle = next_valid_i || (head_valid_i && resp_push_i);

  assign aligned_is_c   = cur_word.rdata[1:0] != 2'b11;
  assign unaligned_is_c = cur_word.rdata[17:16] != 2'b11;

  // Straddling instruction faults if either word faulted
  assign err_unaligned = unaligned_is_c ? cur_word.err : (cur_word.err | second_word.err);

  ////////////////////
  // Output to decode
  ////////////////////

  always_comb begin
    instr_o.addr = addr_q;
    if (addr_q[1]) begin
      instr_o.instr = {second_word.rdata[15:0], cur_word.rdata[31:16]};
      instr_o.err   = err_unaligned;
    end else begin
      instr_o.instr = cur_word.rdata;
      instr_o.err   = cur_word.err;
    end
  end

  always_comb begin
    if (cmd_i.kill) begin
      instr_valid_o = 1'b0;
    end else if (addr_q[1] && !unaligned_is_c) begin
      instr_valid_o = valid_straddle;
    end else begin
      instr_valid_o = valid_any;
    end
  end

  assign emit_o = instr_valid_o && instr_ready_i;
  // Head word is used up unless an aligned compressed leaves its upper half
  assign pop_o  = emit_o && (addr_q[1] || !aligned_is_c);

  ////////////////////
  // Address tracking
  ////////////////////

  assign addr_incr = {addr_q[`ALIGN_XLEN-1:2], 2'b00} + `ALIGN_XLEN'(4);

  always_comb begin
    if (addr_q[1]) begin
      addr_n = {addr_incr[`ALIGN_XLEN-1:2], unaligned_is_c ? 2'b00 : 2'b10};
    end else if (aligned_is_c) begin
      addr_n = {addr_q[`ALIGN_XLEN-1:2], 2'b10};
    end else begin
      addr_n = addr_incr;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (cmd_i.pc_set) begin
      // First instruction after the redirect sits at the target
      addr_q <= branch_addr_i;
    end else if (emit_o) begin
      addr_q <= addr_n;
    end
  end

  // Halfword alignment holds across redirects and increments
  halfword_addr_a: assert property (@(posedge clk) disable iff (!rst_n)
    !addr_q[0]);

endmodule

`default_nettype wire

//--- src/align_buf_top.sv
`default_nettype none

`include "align_macros.svh"

module align_buf_top
  import fetch_bus_pkg::*;
  import fetch_ctrl_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire fetch_cmd_t             cmd_i,
  input  wire logic [`ALIGN_XLEN-1:0] branch_addr_i,
  // Prefetcher side
  output logic                        fetch_valid_o,
  input  wire logic                   fetch_ready_i,
  output fetch_req_t                  fetch_req_o,
  input  wire logic                   resp_valid_i,
  input  wire fetch_resp_t            resp_i,
  // Decode side
  output logic                        instr_valid_o,
  input  wire logic                   instr_ready_i,
  output instr_out_t                  instr_o,
  output logic                        busy_o
);

  logic        resp_push;
  logic [1:0]  n_incoming;
  logic        emit;
  logic        pop;
  fetch_resp_t head;
  fetch_resp_t next;
  logic        head_valid;
  logic        next_valid;

  // Prefetcher always fetches whole words
  assign fetch_req_o.branch      = cmd_i.pc_set;
  assign fetch_req_o.branch_addr = {branch_addr_i[`ALIGN_XLEN-1:2], 2'b00};

  fetch_req_ctrl u_fetch_req_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_i         (cmd_i),
    .fetch_ready_i (fetch_ready_i),
    .resp_valid_i  (resp_valid_i),
    .n_incoming_i  (n_incoming),
    .emit_i        (emit),
    .fetch_valid_o (fetch_valid_o),
    .resp_push_o   (resp_push),
    .busy_o        (busy_o)
  );

  resp_predecode u_resp_predecode (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_i         (cmd_i),
    .branch_addr_i (branch_addr_i),
    .resp_push_i   (resp_push),
    .resp_i        (resp_i),
    .n_incoming_o  (n_incoming)
  );

  resp_fifo u_resp_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_i        (cmd_i),
    .resp_push_i  (resp_push),
    .resp_i       (resp_i),
    .pop_i        (pop),
    .head_o       (head),
    .next_o       (next),
    .head_valid_o (head_valid),
    .next_valid_o (next_valid)
  );

  instr_realigner u_instr_realigner (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_i         (cmd_i),
    .branch_addr_i (branch_addr_i),
    .resp_push_i   (resp_push),
    .resp_i        (resp_i),
    .head_i        (head),
    .next_i        (next),
    .head_valid_i  (head_valid),
    .next_valid_i  (next_valid),
    .instr_ready_i (instr_ready_i),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .pop_o         (pop),
    .emit_o        (emit)
  );

endmodule

`default_nettype wire

//--- verif/align_buf_tb.sv
`default_nettype none

module align_buf_tb
  import fetch_bus_pkg::*;
  import fetch_ctrl_pkg::*;
();

  logic        clk;
  logic        rst_n;
  fetch_cmd_t  cmd;
  logic [31:0] branch_addr;
  logic        fetch_valid;
  logic        fetch_ready;
  fetch_req_t  fetch_req;
  logic        resp_valid;
  fetch_resp_t resp;
  logic        instr_valid;
  logic        instr_ready;
  instr_out_t  instr;
  logic        busy;

  // Memory behind the prefetcher, indexed by address bits 7:2
  logic [31:0] mem_data [64];
  logic        mem_err  [64];

  // Prefetcher state, requests wait here until their response cycle
  logic [31:0] pend_addr_q [$];
  int          pend_due_q  [$];
  logic [31:0] last_req_addr;
  int          last_due;
  int          outstanding;
  int          cycle;

  // Reference model of the decode stream
  logic [31:0] rng_state;
  logic [31:0] exp_addr;
  logic [31:0] branch_target;
  logic        model_active;
  logic        first_after_branch;
  int          emitted;
  int          idle_cycles;
  int          straddle_seen;
  int          unaligned_seen;

  // Instruction held back by decode in the previous cycle
  logic        held_valid;
  logic        held_is_c;
  instr_out_t  held_instr;

  align_buf_top u_align_buf_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_i         (cmd),
    .branch_addr_i (branch_addr),
    .fetch_valid_o (fetch_valid),
    .fetch_ready_i (fetch_ready),
    .fetch_req_o   (fetch_req),
    .resp_valid_i  (resp_valid),
    .resp_i        (resp),
    .instr_valid_o (instr_valid),
    .instr_ready_i (instr_ready),
    .instr_o       (instr),
    .busy_o        (busy)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    return next_rand() % n;
  endfunction

  function automatic logic rand_hit(input int unsigned num, input int unsigned den);
    return rand_below(den) < num;
  endfunction

  // Halfword and error bit seen at a byte address, wrapping over memory
  function automatic logic [15:0] half_at(input logic [31:0] addr);
    logic [31:0] word;
    word = mem_data[addr[7:2]];
    return addr[1] ? word[31:16] : word[15:0];
  endfunction

  function automatic logic err_at(input logic [31:0] addr);
    return mem_err[addr[7:2]];
  endfunction

  task automatic stop_on_failure();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %s: got %h expected %h", name, got, exp);
      stop_on_failure();
    end
  endtask

  ////////////////////
  // Checks
  ////////////////////

  // Parse memory from the expected address and compare the emitted instruction
  task automatic check_emitted_instr();
    logic [15:0] lo_half;
    logic [15:0] hi_half;
    logic        exp_err;
    lo_half = half_at(exp_addr);
    expect_equal("instr_o.addr", instr.addr, exp_addr);
    if (lo_half[1:0] == 2'b11) begin
      // 32-bit, error from every word it touches
      hi_half = half_at(exp_addr + 32'd2);
      exp_err = err_at(exp_addr) | err_at(exp_addr + 32'd2);
      expect_equal("instr_o.instr", instr.instr, {hi_half, lo_half});
      if (exp_addr[1]) begin
        straddle_seen++;
      end
      exp_addr = exp_addr + 32'd4;
    end else begin
      exp_err = err_at(exp_addr);
      expect_equal("instr_o.instr[15:0]", instr.instr[15:0], lo_half);
      exp_addr = exp_addr + 32'd2;
    end
    expect_equal("instr_o.err", instr.err, exp_err);
  endtask

  // Sampled mid cycle, when inputs and outputs have settled
  task automatic observe_cycle();
    logic        grant;
    logic [31:0] req_addr;
    int          due;
    idle_cycles++;
    if (outstanding != 0) begin
      expect_equal("busy_o", busy, 1'b1);
    end
    // No free credit
    if (outstanding >= 2) begin
      expect_equal("fetch_valid_o", fetch_valid, 1'b0);
    end
    // Redirect request goes out in its own cycle
    if (cmd.pc_set) begin
      expect_equal("fetch_valid_o", fetch_valid, 1'b1);
    end
    grant = fetch_valid && fetch_ready;
    if (grant) begin
      expect_equal("fetch_req_o.branch", fetch_req.branch, cmd.pc_set);
      if (cmd.pc_set) begin
        req_addr = branch_addr & 32'hffff_fffc;
        expect_equal("fetch_req_o.branch_addr", fetch_req.branch_addr, req_addr);
      end else begin
        req_addr = last_req_addr + 32'd4;
      end
      last_req_addr = req_addr;
      // In order return, one to three cycles later
      due = cycle + 1 + int'(rand_below(3));
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      pend_addr_q.push_back(req_addr);
      pend_due_q.push_back(due);
      outstanding++;
    end
    if (resp_valid) begin
      outstanding--;
    end
    assert (outstanding <= 2) else begin
      $display("[FAIL] outstanding requests: got %h expected at most %h", outstanding, 2);
      stop_on_failure();
    end
    if (cmd.kill) begin
      expect_equal("instr_valid_o", instr_valid, 1'b0);
    end
    // Back-pressure keeps the meaningful bits steady
    if (held_valid && !cmd.kill && !cmd.pc_set) begin
      expect_equal("instr_valid_o", instr_valid, 1'b1);
      expect_equal("instr_o.addr", instr.addr, held_instr.addr);
      expect_equal("instr_o.err", instr.err, held_instr.err);
      if (held_is_c) begin
        expect_equal("instr_o.instr[15:0]", instr.instr[15:0], held_instr.instr[15:0]);
      end else begin
        expect_equal("instr_o.instr", instr.instr, held_instr.instr);
      end
    end
    held_valid = instr_valid && !instr_ready && !cmd.kill;
    held_instr = instr;
    held_is_c  = instr.instr[1:0] != 2'b11;
    if (instr_valid && instr_ready) begin
      assert (model_active) else begin
        $display("Instruction reached decode before any branch target was set");
        stop_on_failure();
      end
      // First instruction after a redirect sits at the target
      if (first_after_branch) begin
        expect_equal("instr_o.addr", instr.addr, branch_target);
        if (branch_target[1]) begin
          unaligned_seen++;
        end
        first_after_branch = 1'b0;
      end
      check_emitted_instr();
      emitted++;
      idle_cycles = 0;
    end
    if (cmd.pc_set) begin
      exp_addr           = branch_addr;
      branch_target      = branch_addr;
      model_active       = 1'b1;
      first_after_branch = 1'b1;
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic step_cycle(input logic req, input logic set, input logic kill,
                            input logic [31:0] target);
    fetch_resp_t word;
    logic [31:0] addr;
    @(posedge clk);
    cycle++;
    cmd.instr_req <= req;
    cmd.pc_set    <= set;
    cmd.kill      <= kill;
    branch_addr   <= target;
    fetch_ready   <= set ? 1'b1 : rand_hit(3, 4);
    instr_ready   <= rand_hit(2, 3);
    if (pend_due_q.size() > 0 && pend_due_q[0] <= cycle) begin
      addr = pend_addr_q.pop_front();
      pend_due_q.delete(0);
      word.rdata = mem_data[addr[7:2]];
      word.err   = mem_err[addr[7:2]];
      resp_valid <= 1'b1;
    end else begin
      // Junk on the bus between responses
      word.rdata = next_rand();
      word.err   = rand_hit(1, 2);
      resp_valid <= 1'b0;
    end
    resp <= word;
    @(negedge clk);
    observe_cycle();
  endtask

  // Kill for a few cycles, then redirect once a credit is free
  task automatic redirect_fetch();
    logic [31:0] target;
    int          kill_left;
    int          waited;
    target    = next_rand() & 32'hffff_fffe;
    kill_left = int'(rand_below(3));
    waited    = 0;
    while (kill_left > 0 || outstanding >= 2) begin
      step_cycle(1'b0, 1'b0, 1'b1, branch_target);
      if (kill_left > 0) begin
        kill_left--;
      end
      waited++;
      if (waited >= 200) begin
        $display("Timeout: outstanding requests never drained during the kill");
        stop_on_failure();
      end
    end
    step_cycle(1'b1, 1'b1, 1'b1, target);
  endtask

  initial begin
    rng_state          = 32'h1007fcb7;
    rst_n              = 1'b0;
    cmd                = '0;
    branch_addr        = '0;
    fetch_ready        = 1'b0;
    resp_valid         = 1'b0;
    resp               = '0;
    instr_ready        = 1'b0;
    last_req_addr      = '0;
    last_due           = 0;
    outstanding        = 0;
    cycle              = 0;
    exp_addr           = '0;
    branch_target      = '0;
    model_active       = 1'b0;
    first_after_branch = 1'b0;
    emitted            = 0;
    idle_cycles        = 0;
    straddle_seen      = 0;
    unaligned_seen     = 0;
    held_valid         = 1'b0;
    held_is_c          = 1'b0;
    held_instr         = '0;
    // Random halfwords, about one word in eight faulted
    for (int i = 0; i < 64; i++) begin
      mem_data[i] = next_rand();
      mem_err[i]  = rand_hit(1, 8);
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    expect_equal("instr_valid_o", instr_valid, 1'b0);
    expect_equal("busy_o", busy, 1'b0);
    expect_equal("fetch_valid_o", fetch_valid, 1'b0);
    redirect_fetch();
    while (emitted < 400) begin
      if (rand_hit(1, 24)) begin
        redirect_fetch();
      end else begin
        step_cycle(1'b1, 1'b0, 1'b0, branch_target);
      end
      if (idle_cycles >= 200) begin
        $display("Timeout: no instruction reached decode for 200 cycles");
        stop_on_failure();
      end
    end
    if (straddle_seen > 0 && unaligned_seen > 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("Stimulus produced no straddling instruction or no unaligned branch target");
      stop_on_failure();
    end
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+src
src/fetch_bus_pkg.sv
src/fetch_ctrl_pkg.sv
src/fetch_req_ctrl.sv
src/resp_predecode.sv
src/resp_fifo.sv
src/instr_realigner.sv
src/align_buf_top.sv
verif/align_buf_tb.sv

//--- Bender.yml
package:
  name: align_buf

sources:
  - include_dirs:
      - src
    files:
      - src/fetch_bus_pkg.sv
      - src/fetch_ctrl_pkg.sv
      - src/fetch_req_ctrl.sv
      - src/resp_predecode.sv
      - src/resp_fifo.sv
      - src/instr_realigner.sv
      - src/align_buf_top.sv
  - target: test
    files:
      - verif/align_buf_tb.sv
